// ==== common/mac_lb_settings.svh ====
`ifndef MAC_LB_SETTINGS_SVH
`define MAC_LB_SETTINGS_SVH

// Stream word, 64-bit XGMII-side user datapath
`define MAC_LB_DATA_W 64
`define MAC_LB_KEEP_W 8      // One enable per byte lane

// Register bus
`define MAC_LB_APB_ADDR_W 12
`define MAC_LB_APB_DATA_W 32

// Statistics counters, saturating
`define MAC_LB_CNT_W 32

`endif

// ==== common/axis_pkg.sv ====
`default_nettype none

package axis_pkg;

   `include "mac_lb_settings.svh"

   // One stream beat
   typedef logic [`MAC_LB_DATA_W-1:0] data_t;
   typedef logic [`MAC_LB_KEEP_W-1:0] keep_t;

   typedef logic [31:0] half_t;   // Four byte lanes, destination bytes 2..5

   // Where the swapper sits inside a frame
   typedef enum logic [1:0] {
      st_first  = 2'd0,   // Waiting for beat 0
      st_second = 2'd1,   // Beat 0 held, beat 1 pending
      st_rest   = 2'd2    // Payload beats
   } swap_state_e;

endpackage

`default_nettype wire

// ==== common/regs_pkg.sv ====
`default_nettype none

package regs_pkg;

   `include "mac_lb_settings.svh"

   typedef logic [`MAC_LB_APB_ADDR_W-1:0] apb_addr_t;
   typedef logic [`MAC_LB_APB_DATA_W-1:0] apb_data_t;
   typedef logic [`MAC_LB_CNT_W-1:0]      cnt_t;

   // Byte offsets of the register map
   typedef enum logic [`MAC_LB_APB_ADDR_W-1:0] {
      reg_ctrl   = 12'h000,   // Control, read/write
      reg_frames = 12'h004,   // Looped frames, read only
      reg_errors = 12'h008    // Frames with rx tuser set, read only
   } reg_addr_e;

   // Bit positions inside reg_ctrl
   typedef enum logic [4:0] {
      ctrl_swap_en = 5'd0,   // Exchange MAC addresses
      ctrl_clear   = 5'd1    // Self-clearing, zeroes both counters
   } ctrl_bit_e;

endpackage

`default_nettype wire

// ==== rtl/address_swap/xgmac_address_swap.sv ====
`timescale 1ns/1ns
`default_nettype none

module xgmac_address_swap (
   input  wire                clk,
   input  wire                rst_n,
   input  wire                swap_en,
   input  wire axis_pkg::data_t rx_tdata,
   input  wire axis_pkg::keep_t rx_tkeep,
   input  wire                rx_tlast,
   input  wire                rx_tvalid,
   output logic               rx_tready,
   output axis_pkg::data_t    tx_tdata,
   output axis_pkg::keep_t    tx_tkeep,
   output logic               tx_tlast,
   output logic               tx_tvalid,
   input  wire                tx_tready
);

   import axis_pkg::*;

   swap_state_e state;

   // Holding register, one beat deep
   data_t h_data;
   keep_t h_keep;
   logic  h_last;
   logic  h_valid;

   logic  swap_lat;   // swap_en taken at beat 0
   logic  fix_b1;     // Held beat is beat 1 of a swapped frame
   half_t dst_hi;     // Destination bytes 2..5, parked for beat 1

   logic  rx_fire;
   logic  tx_fire;

   // Held beat may go once its successor is on rx, or straight away if last
   assign tx_tvalid = h_valid && (h_last || rx_tvalid);
   assign tx_fire   = tx_tvalid && tx_tready;
   assign rx_tready = !h_valid || tx_fire;   // Room now or by the edge
   assign rx_fire   = rx_tvalid && rx_tready;

   assign tx_tkeep = h_keep;
   assign tx_tlast = h_last;

   always_comb begin
      tx_tdata = h_data;   // Pass through by default
      if (state == st_second && swap_lat) begin
         // Source (lanes 6,7 held + rx lanes 0..3), then destination bytes 0,1
         tx_tdata = {h_data[15:0], rx_tdata[31:0], h_data[63:48]};
      end else if (fix_b1) begin
         tx_tdata = {h_data[63:32], dst_hi};   // Upper lanes untouched
      end
   end

   // Frame position follows accepted rx beats
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_first;
         swap_lat <= 1'b0;
      end else if (rx_fire) begin
         case (state)
            st_first: begin
               swap_lat <= swap_en;   // Held for whole frame
               state    <= rx_tlast ? st_first : st_second;
            end
            st_second: state <= rx_tlast ? st_first : st_rest;
            default:   state <= rx_tlast ? st_first : st_rest;
         endcase
      end
   end

   // Hold occupancy
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         h_valid <= 1'b0;
         fix_b1  <= 1'b0;
      end else begin
         if (rx_fire)
            h_valid <= 1'b1;
         else if (tx_fire)
            h_valid <= 1'b0;
         // Beat 1 enters exactly as beat 0 leaves
         if (tx_fire)
            fix_b1 <= (state == st_second) && swap_lat;
      end
   end

   // Payload side
   always_ff @(posedge clk) begin
      if (rx_fire) begin
         h_data <= rx_tdata;
         h_keep <= rx_tkeep;
         h_last <= rx_tlast;
      end
      if (tx_fire && state == st_second)
         dst_hi <= h_data[47:16];   // Bytes 2..5 of destination
   end

endmodule

`default_nettype wire

// ==== rtl/frame_stats.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_stats (
   input  wire            clk,
   input  wire            rst_n,
   input  wire            rx_tvalid,
   input  wire            rx_tready,
   input  wire            rx_tlast,
   input  wire            rx_tuser,   // Bad-frame flag, valid with tlast
   input  wire            stats_clear,
   output regs_pkg::cnt_t frame_count,
   output regs_pkg::cnt_t error_count
);

   logic last_fire;
   logic frame_full;
   logic error_full;

   // End of frame seen on rx handshake
   assign last_fire = rx_tvalid && rx_tready && rx_tlast;

   // Saturation points
   assign frame_full = &frame_count;
   assign error_full = &error_count;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         frame_count <= '0;
         error_count <= '0;
      end else if (stats_clear) begin
         // Clear wins over a coincident frame end
         frame_count <= '0;
         error_count <= '0;
      end else if (last_fire) begin
         if (!frame_full)
            frame_count <= frame_count + 1'b1;
         if (rx_tuser && !error_full)
            error_count <= error_count + 1'b1;   // Flagged by MAC
      end
   end

endmodule

`default_nettype wire

// ==== rtl/apb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_regs (
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire regs_pkg::apb_addr_t paddr,
   input  wire                 psel,
   input  wire                 penable,
   input  wire                 pwrite,
   input  wire regs_pkg::apb_data_t pwdata,
   output regs_pkg::apb_data_t prdata,
   output logic                pready,
   output logic                pslverr,
   input  wire regs_pkg::cnt_t frame_count,
   input  wire regs_pkg::cnt_t error_count,
   output logic                swap_en,
   output logic                stats_clear
);

   import regs_pkg::*;

   logic access;
   logic mapped;

   assign access = psel && penable;   // Access phase
   assign pready = 1'b1;              // Zero wait states

   // Read mux, valid in the access cycle
   always_comb begin
      prdata = '0;
      mapped = 1'b1;
      case (paddr)
         reg_ctrl:   prdata[ctrl_swap_en] = swap_en;   // Clear bit reads 0
         reg_frames: prdata = frame_count;
         reg_errors: prdata = error_count;
         default:    mapped = 1'b0;   // Hole in map
      endcase
   end

   assign pslverr = access && !mapped;

   // Control register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         swap_en     <= 1'b0;
         stats_clear <= 1'b0;
      end else begin
         stats_clear <= 1'b0;   // Single-cycle pulse
         if (access && pwrite && paddr == reg_ctrl) begin
            swap_en     <= pwdata[ctrl_swap_en];
            stats_clear <= pwdata[ctrl_clear];
         end
         // Counter offsets drop writes, no error
      end
   end

endmodule

`default_nettype wire

// ==== rtl/mac_loopback.sv ====
`timescale 1ns/1ns
`default_nettype none

module mac_loopback (
   input  wire                  clk,
   input  wire                  rst_n,
   // Receive stream from MAC
   input  wire axis_pkg::data_t rx_tdata,
   input  wire axis_pkg::keep_t rx_tkeep,
   input  wire                  rx_tlast,
   input  wire                  rx_tuser,
   input  wire                  rx_tvalid,
   output logic                 rx_tready,
   // Transmit stream to MAC
   output axis_pkg::data_t      tx_tdata,
   output axis_pkg::keep_t      tx_tkeep,
   output logic                 tx_tlast,
   output logic                 tx_tvalid,
   input  wire                  tx_tready,
   // APB slave
   input  wire regs_pkg::apb_addr_t paddr,
   input  wire                  psel,
   input  wire                  penable,
   input  wire                  pwrite,
   input  wire regs_pkg::apb_data_t pwdata,
   output regs_pkg::apb_data_t  prdata,
   output logic                 pready,
   output logic                 pslverr
);

   logic           swap_en;
   logic           stats_clear;   // One-cycle pulse from ctrl write
   regs_pkg::cnt_t frame_count;
   regs_pkg::cnt_t error_count;

   xgmac_address_swap i_xgmac_address_swap (
      .clk       (clk),
      .rst_n     (rst_n),
      .swap_en   (swap_en),
      .rx_tdata  (rx_tdata),
      .rx_tkeep  (rx_tkeep),
      .rx_tlast  (rx_tlast),
      .rx_tvalid (rx_tvalid),
      .rx_tready (rx_tready),
      .tx_tdata  (tx_tdata),
      .tx_tkeep  (tx_tkeep),
      .tx_tlast  (tx_tlast),
      .tx_tvalid (tx_tvalid),
      .tx_tready (tx_tready)
   );

   // Watches the same rx handshake as the swapper
   frame_stats i_frame_stats (
      .clk         (clk),
      .rst_n       (rst_n),
      .rx_tvalid   (rx_tvalid),
      .rx_tready   (rx_tready),
      .rx_tlast    (rx_tlast),
      .rx_tuser    (rx_tuser),
      .stats_clear (stats_clear),
      .frame_count (frame_count),
      .error_count (error_count)
   );

   apb_regs i_apb_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .frame_count (frame_count),
      .error_count (error_count),
      .swap_en     (swap_en),
      .stats_clear (stats_clear)
   );

endmodule

`default_nettype wire

// ==== verif/tb_mac_loopback.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mac_loopback;

   import axis_pkg::*;
   import regs_pkg::*;

   localparam int NUM_FRAMES = 9;
   localparam int MAX_BEATS  = 8;
   localparam int TIMEOUT    = 200;   // Cycles allowed per wait loop

   typedef struct {
      int         beats;
      logic [7:0] last_keep;
      logic       swap;
      logic       user;
      logic       bp;        // Random tx back-pressure
   } frame_cfg_t;

   logic      clk;
   logic      rst_n;
   data_t     rx_tdata;
   keep_t     rx_tkeep;
   logic      rx_tlast;
   logic      rx_tuser;
   logic      rx_tvalid;
   logic      rx_tready;
   data_t     tx_tdata;
   keep_t     tx_tkeep;
   logic      tx_tlast;
   logic      tx_tvalid;
   logic      tx_tready;
   apb_addr_t paddr;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;

   frame_cfg_t  frames [NUM_FRAMES];
   data_t       in_data [MAX_BEATS];
   keep_t       in_keep [MAX_BEATS];
   data_t       exp_data [MAX_BEATS];
   data_t       got_data [MAX_BEATS];
   keep_t       got_keep [MAX_BEATS];
   logic        got_last [MAX_BEATS];
   int          got_count;
   logic [31:0] lcg_state;
   int          test_errs;
   int          n_errors;
   int          n_tests;
   int          n_failed;

   mac_loopback i_mac_loopback (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // 40 ns period
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
         test_errs++;
      end
   endtask

   task automatic report_test(input string name);
      n_tests++;
      n_errors += test_errs;
      if (test_errs != 0)
         n_failed++;
      $display("test %-40s %s", name, (test_errs == 0) ? "ok" : "FAIL");
      test_errs = 0;
   endtask

   // One APB transfer, setup then access, entered at posedge + 2 ns
   task automatic apb_transfer(input apb_addr_t addr, input logic write, input apb_data_t wdata,
                               output apb_data_t rdata, output logic err);
      int t;
      paddr   = addr;
      pwrite  = write;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #2;
      penable = 1'b1;
      t = 0;
      @(negedge clk);
      while (!pready && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (!pready) begin
         $display("APB access to offset %h never saw pready", addr);
         test_errs++;
      end
      rdata = prdata;   // Stable at mid-cycle
      err   = pslverr;
      @(posedge clk);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   // Random payload plus expected output from the byte-level swap rule
   task automatic build_frame(input frame_cfg_t cfg);
      logic [7:0]  b [0:8*MAX_BEATS-1];
      logic [7:0]  tmp;
      logic [31:0] hi;
      logic [31:0] lo;
      int          i;
      int          k;
      for (i = 0; i < cfg.beats; i++) begin
         hi = next_random();
         lo = next_random();
         in_data[i] = {hi, lo};
         in_keep[i] = (i == cfg.beats - 1) ? cfg.last_keep : 8'hff;
         for (k = 0; k < 8; k++)
            b[8*i+k] = in_data[i][8*k +: 8];   // Byte 0 in bits 7..0
      end
      // Bytes 0..5 trade places with bytes 6..11
      if (cfg.swap && cfg.beats > 1) begin
         for (k = 0; k < 6; k++) begin
            tmp    = b[k];
            b[k]   = b[k+6];
            b[k+6] = tmp;
         end
      end
      for (i = 0; i < cfg.beats; i++)
         for (k = 0; k < 8; k++)
            exp_data[i][8*k +: 8] = b[8*i+k];
   endtask

   task automatic send_frame(input frame_cfg_t cfg);
      int   i;
      int   t;
      logic accepted;
      for (i = 0; i < cfg.beats; i++) begin
         rx_tdata  = in_data[i];
         rx_tkeep  = in_keep[i];
         rx_tlast  = (i == cfg.beats - 1);
         rx_tuser  = cfg.user && (i == cfg.beats - 1);   // Flag rides on last beat
         rx_tvalid = 1'b1;
         accepted  = 1'b0;
         t = 0;
         while (!accepted && t < TIMEOUT) begin
            @(negedge clk);
            accepted = rx_tready;   // Handshake on the coming edge
            @(posedge clk);
            #2;
            t++;
         end
         if (!accepted) begin
            $display("rx_tready stayed low, beat %0d of the frame was never taken", i);
            test_errs++;
            break;
         end
      end
      rx_tvalid = 1'b0;
      rx_tlast  = 1'b0;
      rx_tuser  = 1'b0;
   endtask

   task automatic collect_frame(input frame_cfg_t cfg);
      int          n;
      int          t;
      logic [31:0] r;
      n = 0;
      t = 0;
      r = next_random();
      tx_tready = cfg.bp ? r[20] : 1'b1;
      while (n < cfg.beats && t < TIMEOUT) begin
         @(negedge clk);
         if (tx_tvalid && tx_tready) begin
            got_data[n] = tx_tdata;
            got_keep[n] = tx_tkeep;
            got_last[n] = tx_tlast;
            n++;
            t = 0;
         end else begin
            t++;
         end
         @(posedge clk);
         #2;
         r = next_random();
         tx_tready = cfg.bp ? r[20] : 1'b1;
      end
      if (n < cfg.beats) begin
         $display("only %0d of %0d tx beats came out before the timeout", n, cfg.beats);
         test_errs++;
      end
      got_count = n;
   endtask

   initial begin
      frame_cfg_t cfg;
      apb_data_t  rdata;
      apb_data_t  wdata;
      logic       err;
      int         n_user;
      int         i;
      lcg_state = 32'hd30e;
      test_errs = 0;
      n_errors  = 0;
      n_tests   = 0;
      n_failed  = 0;
      n_user    = 0;
      rst_n     = 1'b0;
      rx_tdata  = '0;
      rx_tkeep  = '0;
      rx_tlast  = 1'b0;
      rx_tuser  = 1'b0;
      rx_tvalid = 1'b0;
      tx_tready = 1'b1;
      paddr     = '0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      pwdata    = '0;
      // beats, final tkeep, swap_en, rx_tuser, back-pressure
      frames[0] = '{2, 8'hff, 1'b1, 1'b0, 1'b0};
      frames[1] = '{3, 8'h0f, 1'b1, 1'b1, 1'b0};
      frames[2] = '{8, 8'h3f, 1'b1, 1'b0, 1'b0};
      frames[3] = '{3, 8'hff, 1'b0, 1'b0, 1'b0};   // Swap off
      frames[4] = '{1, 8'h7f, 1'b1, 1'b1, 1'b0};   // Runt, passes as is
      frames[5] = '{1, 8'hff, 1'b0, 1'b0, 1'b0};
      frames[6] = '{8, 8'h01, 1'b1, 1'b0, 1'b1};
      frames[7] = '{2, 8'hff, 1'b0, 1'b1, 1'b1};
      frames[8] = '{5, 8'h03, 1'b1, 1'b0, 1'b1};

      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;

      @(negedge clk);
      check_value("tx_tvalid", 1'b0, tx_tvalid);
      @(posedge clk);
      #2;
      apb_transfer(reg_ctrl, 1'b0, '0, rdata, err);
      check_value("reg_ctrl", '0, rdata);
      check_value("pslverr", 1'b0, err);
      apb_transfer(reg_frames, 1'b0, '0, rdata, err);
      check_value("reg_frames", '0, rdata);
      check_value("pslverr", 1'b0, err);
      apb_transfer(reg_errors, 1'b0, '0, rdata, err);
      check_value("reg_errors", '0, rdata);
      check_value("pslverr", 1'b0, err);
      report_test("reset values");

      for (i = 0; i < NUM_FRAMES; i++) begin
         cfg = frames[i];
         wdata = '0;
         wdata[ctrl_swap_en] = cfg.swap;
         apb_transfer(reg_ctrl, 1'b1, wdata, rdata, err);
         check_value("pslverr", 1'b0, err);
         build_frame(cfg);
         fork
            send_frame(cfg);
            collect_frame(cfg);
         join
         for (int b = 0; b < got_count; b++) begin
            check_value($sformatf("tx_tdata[%0d]", b), exp_data[b], got_data[b]);
            check_value($sformatf("tx_tkeep[%0d]", b), in_keep[b], got_keep[b]);
            check_value($sformatf("tx_tlast[%0d]", b), b == cfg.beats - 1, got_last[b]);
         end
         if (cfg.user)
            n_user++;
         tx_tready = 1'b1;
         report_test($sformatf("frame %0d: %0d beats swap %0d bp %0d",
                               i, cfg.beats, cfg.swap, cfg.bp));
      end

      apb_transfer(reg_frames, 1'b0, '0, rdata, err);
      check_value("reg_frames", NUM_FRAMES, rdata);
      apb_transfer(reg_errors, 1'b0, '0, rdata, err);
      check_value("reg_errors", n_user, rdata);
      report_test("frame and error counters");

      wdata = '0;
      wdata[ctrl_clear] = 1'b1;
      apb_transfer(reg_ctrl, 1'b1, wdata, rdata, err);
      apb_transfer(reg_frames, 1'b0, '0, rdata, err);
      check_value("reg_frames", '0, rdata);
      apb_transfer(reg_errors, 1'b0, '0, rdata, err);
      check_value("reg_errors", '0, rdata);
      apb_transfer(reg_ctrl, 1'b0, '0, rdata, err);
      check_value("reg_ctrl clear bit", 1'b0, rdata[ctrl_clear]);
      report_test("counter clear");

      wdata = '0;
      wdata[ctrl_swap_en] = 1'b1;
      apb_transfer(reg_ctrl, 1'b1, wdata, rdata, err);
      apb_transfer(12'h00c, 1'b1, '0, rdata, err);   // Zero data would drop swap_en
      check_value("pslverr on write", 1'b1, err);
      apb_transfer(12'h00c, 1'b0, '0, rdata, err);
      check_value("pslverr on read", 1'b1, err);
      check_value("prdata", '0, rdata);
      apb_transfer(reg_ctrl, 1'b0, '0, rdata, err);
      check_value("reg_ctrl swap bit", 1'b1, rdata[ctrl_swap_en]);
      check_value("pslverr", 1'b0, err);
      report_test("unmapped offset");

      $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, n_errors);
      if (n_errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/axis_pkg.sv
common/regs_pkg.sv
rtl/address_swap/xgmac_address_swap.sv
rtl/frame_stats.sv
rtl/apb_regs.sv
rtl/mac_loopback.sv
verif/tb_mac_loopback.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -Wno-fatal
TOP       := tb_mac_loopback
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
